// ==== Makefile ====
TOP = tb_motion

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation passed" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f verilog.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// ==== tests/motion_checker.sv ====
`default_nettype none

module motion_checker import motion_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  reg_write_t host_wr,
    input  logic [num_motors-1:0] motor_step,
    input  logic [num_motors-1:0] motor_dir,
    input  logic [num_motors-1:0] motor_enable,
    input  logic [2:0] test_id,
    input  logic running,
    input  logic test_end,
    output int errors,
    output int tests_failed
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [speed_width-1:0] m_speed [num_channels];
    logic [speed_width-1:0] m_acc [num_channels];
    channel_out_t m_chan [num_channels];
    step_bit_t m_bit;
    pulse_timing_t m_tim;
    motor_cfg_t m_cfg [num_motors];
    channel_out_t m_route [num_motors];
    int m_phase [num_motors];   // 0 idle, 1 setup, 2 pulse, 3 hold
    int m_left [num_motors];    // cycles left in the phase
    logic m_pdir [num_motors];
    int hi_run [num_motors];
    int lo_run [num_motors];
    int rises [num_motors];
    bit seen [num_motors];
    bit prev [num_motors];
    int test_errors;

    function automatic int span(input logic [timing_width-1:0] n);
        return (n == '0) ? 1 : int'(n);
    endfunction

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd0: return "idle after reset";
            3'd1: return "random speeds";
            3'd2: return "routing and inversion";
            3'd3: return "motor enable";
            default: return "unused addresses";
        endcase
    endfunction

    task automatic count_error();
        test_errors++;
        errors++;
    endtask

    task automatic value_error(input string what, input int m, input int got, input int exp);
        $display("error at %0t ns: motor %0d %s is %0d, expected %0d", $time, m, what, got, exp);
        count_error();
    endtask

    task automatic finish_test();
        logic moving;
        for (int m = 0; m < num_motors; m++) begin
            moving = m_speed[m_cfg[m].sel] != '0;
            if (m_cfg[m].enable && moving && rises[m] == 0) begin
                $display("motor %0d never stepped although its channel is moving", m);
                count_error();
            end else if (!(m_cfg[m].enable && moving) && rises[m] != 0) begin
                $display("motor %0d stepped while disabled or on a channel at rest", m);
                count_error();
            end
            rises[m] = 0;
        end
        if (test_errors == 0) begin
            $display("test %0d (%s) passed", test_id, test_name(test_id));
        end else begin
            $display("test %0d (%s) failed with %0d errors", test_id, test_name(test_id),
                     test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    // model stages run back to front so each one sees last cycle's values
    always @(posedge clk) begin
        logic [speed_width-1:0] sum;
        int a;
        if (rst) begin
            m_speed = '{default: '0};
            m_acc = '{default: '0};
            m_chan = '{default: '0};
            m_cfg = '{default: '0};
            m_route = '{default: '0};
            m_phase = '{default: 0};
            m_bit = '0;
            m_tim = '0;
        end else begin
            for (int m = 0; m < num_motors; m++) begin
                if (m_phase[m] == 0) begin
                    if (m_route[m].step) begin
                        m_phase[m] = 1;
                        m_left[m] = span(m_tim.pre_n);
                        m_pdir[m] = m_route[m].dir;
                    end
                end else if (m_left[m] > 1) begin
                    m_left[m]--;
                end else begin
                    m_phase[m] = (m_phase[m] + 1) % 4;
                    m_left[m] = span(m_phase[m] == 2 ? m_tim.pulse_n : m_tim.post_n);
                end
            end
            for (int m = 0; m < num_motors; m++) begin
                m_route[m].step = m_chan[m_cfg[m].sel].step && m_cfg[m].enable;
                m_route[m].dir = m_chan[m_cfg[m].sel].dir ^ m_cfg[m].invert_dir;
            end
            for (int c = 0; c < num_channels; c++) begin
                sum = m_acc[c] + m_speed[c];
                m_chan[c].step = sum[m_bit] != m_acc[c][m_bit];
                m_chan[c].dir = m_speed[c][speed_width-1];
                m_acc[c] = sum;
            end
            if (host_wr.stb) begin
                a = int'(host_wr.addr);
                if (a < 8) begin
                    m_speed[a] = host_wr.data;
                end else if (a == 8) begin
                    m_bit = host_wr.data[4:0];
                end else if (a == 9) begin
                    m_tim = '{pre_n: host_wr.data[7:0], pulse_n: host_wr.data[15:8],
                              post_n: host_wr.data[23:16]};
                end else if (a >= 16 && a < 28) begin
                    m_cfg[a-16] = '{sel: host_wr.data[2:0], invert_dir: host_wr.data[4],
                                    enable: host_wr.data[3]};
                end
            end
        end
    end

    always @(negedge clk) begin
        int min_gap;
        if (!rst) begin
            for (int m = 0; m < num_motors; m++) begin
                // strobe waiting for the next edge while the sequence still runs
                if (m_route[m].step && m_phase[m] != 0) begin
                    $display("motor %0d got a step strobe before its last pulse ended", m);
                    count_error();
                end
                if (motor_step[m] !== (m_phase[m] == 2))
                    value_error("step", m, int'(motor_step[m]), int'(m_phase[m] == 2));
                if (motor_dir[m] !== (m_pdir[m] && m_phase[m] != 0))
                    value_error("dir", m, int'(motor_dir[m]), int'(m_pdir[m] && m_phase[m] != 0));
                if (motor_enable[m] !== m_cfg[m].enable)
                    value_error("enable", m, int'(motor_enable[m]), int'(m_cfg[m].enable));
                min_gap = span(m_tim.pre_n) + span(m_tim.post_n);
                if (motor_step[m]) begin
                    if (!prev[m] && seen[m] && lo_run[m] < min_gap)
                        value_error("low gap", m, lo_run[m], min_gap);
                    if (!prev[m] && running)
                        rises[m]++;
                    hi_run[m]++;
                    lo_run[m] = 0;
                end else begin
                    if (prev[m] && hi_run[m] != span(m_tim.pulse_n))
                        value_error("pulse width", m, hi_run[m], span(m_tim.pulse_n));
                    if (prev[m])
                        seen[m] = 1'b1;
                    hi_run[m] = 0;
                    lo_run[m]++;
                end
                prev[m] = motor_step[m];
            end
            if (test_id == 3'd0 && (motor_step | motor_dir | motor_enable) != '0) begin
                $display("an output went high before any register write");
                count_error();
            end
            if (test_end)
                finish_test();
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_motion.sv ====
`default_nettype none

module tb_motion import motion_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period = 8;
    localparam int reset_cycles = 10;
    localparam int quiet_cycles = 40;   // longer than any pulse sequence
    localparam int setup_cycles = 30;
    localparam int num_tests = 5;
    localparam int run_len [num_tests] = '{200, 600, 600, 600, 600};
    localparam int seed = 32'h9b3b;

    logic clk;
    logic rst;
    reg_write_t host_wr;
    logic [num_motors-1:0] motor_step;
    logic [num_motors-1:0] motor_dir;
    logic [num_motors-1:0] motor_enable;
    logic [2:0] test_id;
    logic running;
    logic test_end;
    int errors;
    int tests_failed;
    pulse_timing_t tim;
    int sb;

    motion_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .host_wr      (host_wr),
        .motor_step   (motor_step),
        .motor_dir    (motor_dir),
        .motor_enable (motor_enable)
    );

    motion_checker checker_i (
        .clk          (clk),
        .rst          (rst),
        .host_wr      (host_wr),
        .motor_step   (motor_step),
        .motor_dir    (motor_dir),
        .motor_enable (motor_enable),
        .test_id      (test_id),
        .running      (running),
        .test_end     (test_end),
        .errors       (errors),
        .tests_failed (tests_failed)
    );

    function automatic int total_cycles();
        int sum;
        sum = reset_cycles;
        foreach (run_len[k])
            sum += run_len[k] + quiet_cycles + setup_cycles + 2;
        return sum;
    endfunction

    // keeps the stroke interval longer than a full pulse sequence
    function automatic logic [31:0] pick_speed(input int bit_idx, input pulse_timing_t t);
        int limit;
        int mag;
        limit = (1 << bit_idx) / (int'(t.pre_n) + int'(t.pulse_n) + int'(t.post_n) + 4);
        mag = limit / 2 + int'($urandom % (limit / 2 + 1));
        return ($urandom_range(1) == 1) ? 32'(-mag) : 32'(mag);
    endfunction

    function automatic logic [4:0] unused_addr();
        logic [4:0] a;
        a = 5'($urandom_range(9));
        return (a < 6) ? a + 5'd10 : a + 5'd22;   // 10..15 or 28..31
    endfunction

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        host_wr <= '{stb: 1'b1, addr: reg_addr_e'(addr), data: data};
        @(posedge clk);
        host_wr.stb <= 1'b0;
    endtask

    task automatic run_test(input int k);
        logic [2:0] sel;
        logic inv;
        logic en;
        int c_fixed;
        test_id <= 3'(k);
        c_fixed = $urandom_range(7);
        if (k > 0) begin
            for (int c = 0; c < num_channels; c++)
                write_reg(5'(c), 32'd0);
            repeat (quiet_cycles) @(posedge clk);
            tim = '{pre_n: 8'($urandom_range(7)), pulse_n: 8'($urandom_range(7)),
                    post_n: 8'($urandom_range(7))};
            sb = 9 + $urandom_range(3);
            write_reg(reg_pulse_timing, {8'd0, tim.post_n, tim.pulse_n, tim.pre_n});
            write_reg(reg_step_bit, 32'(sb));
            for (int m = 0; m < num_motors; m++) begin
                sel = (k == 3 || (k == 2 && m == 0)) ? 3'(c_fixed) : 3'($urandom_range(7));
                inv = (k == 2 || k == 3) ? 1'($urandom_range(1)) : 1'b0;
                en = (k != 3 || m == 0) ? 1'b1 : (m == 1) ? 1'b0 : 1'($urandom_range(1));
                write_reg(5'(int'(reg_motor_cfg_0) + m), {27'd0, inv, en, sel});
            end
            for (int c = 0; c < num_channels; c++)
                write_reg(5'(c), (k == 2 && c == c_fixed) ? 32'd0 : pick_speed(sb, tim));
        end
        running <= 1'b1;
        for (int i = 0; i < run_len[k]; i++) begin
            if (k == 4 && $urandom_range(7) == 0)
                host_wr <= '{stb: 1'b1, addr: reg_addr_e'(unused_addr()), data: $urandom};
            else
                host_wr.stb <= 1'b0;
            @(posedge clk);
        end
        host_wr.stb <= 1'b0;
        running <= 1'b0;
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        void'($urandom(seed));
        rst = 1'b1;
        host_wr = '0;
        test_id = '0;
        running = 1'b0;
        test_end = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        for (int k = 0; k < num_tests; k++)
            run_test(k);
        @(posedge clk);
        $display("%0d tests run, %0d failed, %0d errors", num_tests, tests_failed, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    initial begin
        #(2 * total_cycles() * clk_period);
        $display("watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
verilog/motion_pkg.sv
verilog/motion_regs.sv
verilog/speed_integrator.sv
verilog/motor_router.sv
verilog/step_pulse_gen.sv
verilog/motion_top.sv
tests/motion_checker.sv
tests/tb_motion.sv

// ==== verilog/motion_pkg.sv ====
`default_nettype none

package motion_pkg;

    localparam int num_channels = 8;
    localparam int num_motors = 12;
    localparam int speed_width = 32;
    localparam int timing_width = 8;

    // host register map
    typedef enum logic [4:0] {
        reg_speed_0 = 5'd0, reg_speed_1, reg_speed_2, reg_speed_3,
        reg_speed_4, reg_speed_5, reg_speed_6, reg_speed_7,
        reg_step_bit = 5'd8,
        reg_pulse_timing = 5'd9,
        reg_motor_cfg_0 = 5'd16, reg_motor_cfg_1, reg_motor_cfg_2, reg_motor_cfg_3,
        reg_motor_cfg_4, reg_motor_cfg_5, reg_motor_cfg_6, reg_motor_cfg_7,
        reg_motor_cfg_8, reg_motor_cfg_9, reg_motor_cfg_10, reg_motor_cfg_11
    } reg_addr_e;

    typedef struct packed {
        logic stb;           // one-cycle write strobe
        reg_addr_e addr;
        logic [31:0] data;
    } reg_write_t;

    typedef struct packed {
        logic [timing_width-1:0] pre_n;    // data[7:0]
        logic [timing_width-1:0] pulse_n;  // data[15:8]
        logic [timing_width-1:0] post_n;   // data[23:16]
    } pulse_timing_t;

    typedef struct packed {
        logic [2:0] sel;     // channel number, data[2:0]
        logic invert_dir;    // data[4]
        logic enable;        // data[3]
    } motor_cfg_t;

    typedef struct packed {
        logic step;
        logic dir;
    } channel_out_t;

    typedef logic [4:0] step_bit_t;

endpackage

`default_nettype wire

// ==== verilog/motion_regs.sv ====
`default_nettype none

module motion_regs import motion_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  reg_write_t host_wr,
    output logic [speed_width-1:0] speeds [num_channels],
    output step_bit_t step_bit,
    output pulse_timing_t timing,
    output motor_cfg_t cfg [num_motors]
);

    logic is_speed;
    logic is_cfg;

    assign is_speed = host_wr.addr inside {[reg_speed_0:reg_speed_7]};
    assign is_cfg = host_wr.addr inside {[reg_motor_cfg_0:reg_motor_cfg_11]};

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_channels; i++) begin
                speeds[i] <= '0;
            end
            for (int i = 0; i < num_motors; i++) begin
                cfg[i] <= '0;
            end
            step_bit <= '0;
            timing <= '0;
        end else if (host_wr.stb) begin
            if (is_speed) begin
                speeds[host_wr.addr[2:0]] <= host_wr.data;
            end else if (is_cfg) begin
                cfg[host_wr.addr[3:0]].sel <= host_wr.data[2:0];      // 16..27 -> 0..11
                cfg[host_wr.addr[3:0]].enable <= host_wr.data[3];
                cfg[host_wr.addr[3:0]].invert_dir <= host_wr.data[4];
            end else if (host_wr.addr == reg_step_bit) begin
                step_bit <= host_wr.data[4:0];
            end else if (host_wr.addr == reg_pulse_timing) begin
                timing.pre_n <= host_wr.data[7:0];
                timing.pulse_n <= host_wr.data[15:8];
                timing.post_n <= host_wr.data[23:16];
            end
            // unmapped addresses fall through
        end
    end

    // host must drive a clean strobe once out of reset
    stb_known: assert property (
        @(posedge clk) disable iff (rst) !$isunknown(host_wr.stb)
    );

endmodule

`default_nettype wire

// ==== verilog/motion_top.sv ====
`default_nettype none

module motion_top import motion_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  reg_write_t host_wr,
    output logic [num_motors-1:0] motor_step,
    output logic [num_motors-1:0] motor_dir,
    output logic [num_motors-1:0] motor_enable
);

    logic [speed_width-1:0] speeds [num_channels];
    step_bit_t step_bit;
    pulse_timing_t timing;
    motor_cfg_t cfg [num_motors];
    channel_out_t chans [num_channels];
    channel_out_t motors [num_motors];

    motion_regs regs_i (
        .clk      (clk),
        .rst      (rst),
        .host_wr  (host_wr),
        .speeds   (speeds),
        .step_bit (step_bit),
        .timing   (timing),
        .cfg      (cfg)
    );

    for (genvar c = 0; c < num_channels; c++) begin : g_chan
        speed_integrator integ_i (
            .clk      (clk),
            .rst      (rst),
            .speed    (speeds[c]),
            .step_bit (step_bit),
            .chan     (chans[c])
        );
    end

    motor_router router_i (
        .clk    (clk),
        .rst    (rst),
        .chans  (chans),
        .cfg    (cfg),
        .motors (motors)
    );

    for (genvar m = 0; m < num_motors; m++) begin : g_motor
        step_pulse_gen pgen_i (
            .clk    (clk),
            .rst    (rst),
            .req    (motors[m]),
            .timing (timing),
            .step   (motor_step[m]),
            .dir    (motor_dir[m])
        );
        assign motor_enable[m] = cfg[m].enable;
    end

endmodule

`default_nettype wire

// ==== verilog/motor_router.sv ====
`default_nettype none

module motor_router import motion_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  channel_out_t chans [num_channels],
    input  motor_cfg_t cfg [num_motors],
    output channel_out_t motors [num_motors]
);

    channel_out_t picked [num_motors];

    always_comb begin
        for (int m = 0; m < num_motors; m++) begin
            picked[m] = chans[cfg[m].sel];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int m = 0; m < num_motors; m++) begin
                motors[m] <= '0;
            end
        end else begin
            for (int m = 0; m < num_motors; m++) begin
                motors[m].step <= picked[m].step & cfg[m].enable;    // disabled motor never steps
                motors[m].dir <= picked[m].dir ^ cfg[m].invert_dir;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/speed_integrator.sv ====
`default_nettype none

module speed_integrator import motion_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic [speed_width-1:0] speed,
    input  step_bit_t step_bit,
    output channel_out_t chan
);

    logic [speed_width-1:0] acc;
    logic [speed_width-1:0] acc_next;
    logic crossed;

    assign acc_next = acc + speed;  // wraps at 32 bits
    assign crossed = acc_next[step_bit] ^ acc[step_bit];

    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
            chan <= '0;
        end else begin
            acc <= acc_next;
            chan.step <= crossed;
            chan.dir <= speed[speed_width-1];  // sign gives direction
        end
    end

endmodule

`default_nettype wire

// ==== verilog/step_pulse_gen.sv ====
`default_nettype none

module step_pulse_gen import motion_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  channel_out_t req,
    input  pulse_timing_t timing,
    output logic step,
    output logic dir
);

    typedef enum logic [1:0] {
        idle,
        setup,
        pulse,
        hold
    } step_state_e;

    step_state_e state;
    logic [timing_width-1:0] cnt;
    logic dir_q;

    // zero counts as a single cycle
    function automatic logic [timing_width-1:0] load_cnt(input logic [timing_width-1:0] n);
        return (n == '0) ? '0 : n - 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            cnt <= '0;
            dir_q <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (req.step) begin
                        state <= setup;
                        cnt <= load_cnt(timing.pre_n);
                        dir_q <= req.dir;   // latched for the whole sequence
                    end
                end
                setup: begin
                    if (cnt == '0) begin
                        state <= pulse;
                        cnt <= load_cnt(timing.pulse_n);
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                pulse: begin
                    if (cnt == '0) begin
                        state <= hold;
                        cnt <= load_cnt(timing.post_n);
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                hold: begin
                    if (cnt == '0) begin
                        state <= idle;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    assign step = (state == pulse);
    assign dir = dir_q & (state != idle);

    // no queue here, so the channel rate must leave room for a full sequence
    no_overrun: assert property (
        @(posedge clk) disable iff (rst) req.step |-> state == idle
    );

endmodule

`default_nettype wire
